// File: sim.f
verilog/mmio_pkg.sv
verilog/apb_arbiter.sv
verilog/mmio_decoder.sv
verilog/seg_display.sv
verilog/event_counter.sv
verilog/uart_tx.sv
verilog/mmio_top.sv
tb/tb_clock.sv
tb/mmio_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= mmio_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/mmio_tb.sv
module mmio_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int SCAN_DIV     = 4;
  localparam int BAUD_DIV     = 8;
  localparam int FIFO_DEPTH   = 4;
  localparam int XFER_LIMIT   = 40;
  localparam int SCAN_SAMPLES = 17 * SCAN_DIV;
  localparam int UART_BYTES   = 8;
  localparam int UART_WAIT    = 10 * BAUD_DIV * (UART_BYTES + 1);
  localparam logic [31:0] CMP_VALUE = 32'd32;
  // Bytes on the line, two display scans, transfers, slack
  localparam int RUN_CYCLES = 10 * BAUD_DIV * UART_BYTES + 2 * BAUD_DIV +
                              2 * (SCAN_SAMPLES + SCAN_DIV) + 100 * 8 + 200;

  logic               clk;
  logic               rst_n;
  mmio_pkg::apb_req_t core_req;
  mmio_pkg::apb_rsp_t core_rsp;
  mmio_pkg::apb_req_t dbg_req;
  mmio_pkg::apb_rsp_t dbg_rsp;
  logic               debug;
  logic [7:0]         an;
  logic [6:0]         sev_out;
  logic               tx;
  logic               cnt_irq;

  int          errors;
  logic [31:0] rng;
  time         done_at [2];
  logic [7:0]  exp_q [$];

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mmio_top #(
    .SCAN_DIV   (SCAN_DIV),
    .BAUD_DIV   (BAUD_DIV),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .dbg_req  (dbg_req),
    .dbg_rsp  (dbg_rsp),
    .debug    (debug),
    .an       (an),
    .sev_out  (sev_out),
    .tx       (tx),
    .cnt_irq  (cnt_irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic string rsp_name(input logic from_dbg, input logic [7:0] addr);
    return $sformatf("%s @%02h", from_dbg ? "dbg_rsp" : "core_rsp", addr);
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_rsp(input string name, input mmio_pkg::apb_rsp_t got,
                           input logic exp_err);
    if (got.pready !== 1'b1 || got.pslverr !== exp_err) begin
      errors++;
      $display("MISMATCH at %0t: %s pready/pslverr got %b/%b expected 1/%b",
               $time, name, got.pready, got.pslverr, exp_err);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_seg(input string name, input logic [7:0] got_an,
                           input logic [6:0] got_seg, input logic [7:0] exp_an,
                           input logic [6:0] exp_seg);
    if (got_an !== exp_an || got_seg !== exp_seg) begin
      errors++;
      $display("MISMATCH at %0t: %s got %02h/%02h expected %02h/%02h",
               $time, name, got_an, got_seg, exp_an, exp_seg);
    end
  endtask

  task automatic drive_master(input logic from_dbg, input mmio_pkg::apb_req_t req);
    if (from_dbg) begin
      dbg_req = req;
    end else begin
      core_req = req;
    end
  endtask

  // One APB transfer from either master, setup then access until pready
  task automatic bus_xfer(input logic from_dbg, input logic [7:0] addr, input logic wr,
                          input logic [31:0] wdata, output mmio_pkg::apb_rsp_t rsp);
    mmio_pkg::apb_req_t req;
    int                 waited;
    req        = '0;
    req.paddr  = addr;
    req.psel   = 1'b1;
    req.pwrite = wr;
    req.pwdata = wdata;
    waited     = 0;
    rsp        = '0;
    @(negedge clk);
    drive_master(from_dbg, req);
    @(negedge clk);
    req.penable = 1'b1;
    drive_master(from_dbg, req);
    while (!rsp.pready && waited < XFER_LIMIT) begin
      @(negedge clk);
      waited++;
      rsp = from_dbg ? dbg_rsp : core_rsp;
    end
    if (!rsp.pready) begin
      report_error($sformatf("no pready for %s", rsp_name(from_dbg, addr)));
    end else begin
      done_at[from_dbg] = $time;
    end
    // Hold through the completing edge
    @(negedge clk);
    drive_master(from_dbg, '0);
  endtask

  task automatic write_reg(input logic from_dbg, input logic [7:0] addr,
                           input logic [31:0] data, input logic exp_err);
    mmio_pkg::apb_rsp_t rsp;
    bus_xfer(from_dbg, addr, 1'b1, data, rsp);
    check_rsp(rsp_name(from_dbg, addr), rsp, exp_err);
  endtask

  task automatic read_reg(input logic from_dbg, input logic [7:0] addr,
                          input logic exp_err, output logic [31:0] data);
    mmio_pkg::apb_rsp_t rsp;
    bus_xfer(from_dbg, addr, 1'b0, 32'h0, rsp);
    check_rsp(rsp_name(from_dbg, addr), rsp, exp_err);
    data = rsp.prdata;
  endtask

  task automatic expect_reg(input logic from_dbg, input logic [7:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    read_reg(from_dbg, addr, 1'b0, data);
    check_word($sformatf("prdata @%02h", addr), data, exp);
  endtask

  task automatic access_registers();
    logic [7:0]  regs [3];
    logic [31:0] vals [3];
    logic [31:0] data;
    regs[0] = mmio_pkg::disp_core;
    regs[1] = mmio_pkg::disp_debug;
    regs[2] = mmio_pkg::cnt_compare;
    for (int i = 0; i < 3; i++) begin
      vals[i] = next_rand();
      write_reg(1'(i), regs[i], vals[i], 1'b0);
    end
    for (int i = 0; i < 3; i++) begin
      expect_reg(1'b0, regs[i], vals[i]);
      expect_reg(1'b1, regs[i], vals[i]);
    end
    read_reg(1'b0, 8'h08, 1'b1, data);
    read_reg(1'b1, 8'h30, 1'b1, data);
    write_reg(1'b0, mmio_pkg::cnt_value, next_rand(), 1'b1);
  endtask

  task automatic contend_for_bus();
    logic [31:0]        a;
    logic [31:0]        b;
    mmio_pkg::apb_rsp_t rc;
    mmio_pkg::apb_rsp_t rd;
    a = next_rand();
    b = next_rand();
    fork
      bus_xfer(1'b0, mmio_pkg::disp_core, 1'b1, a, rc);
      bus_xfer(1'b1, mmio_pkg::cnt_compare, 1'b1, b, rd);
    join
    check_rsp("core_rsp contended", rc, 1'b0);
    check_rsp("dbg_rsp contended", rd, 1'b0);
    if (done_at[0] >= done_at[1]) begin
      report_error("core did not win the first contended grant");
    end
    expect_reg(1'b1, mmio_pkg::disp_core, a);
    expect_reg(1'b0, mmio_pkg::cnt_compare, b);
    // Round robin hands the next tie to debug
    a = next_rand();
    b = next_rand();
    fork
      bus_xfer(1'b0, mmio_pkg::disp_debug, 1'b1, a, rc);
      bus_xfer(1'b1, mmio_pkg::disp_core, 1'b1, b, rd);
    join
    check_rsp("core_rsp contended", rc, 1'b0);
    check_rsp("dbg_rsp contended", rd, 1'b0);
    if (done_at[1] >= done_at[0]) begin
      report_error("debug did not win the second contended grant");
    end
    expect_reg(1'b1, mmio_pkg::disp_debug, a);
    expect_reg(1'b0, mmio_pkg::disp_core, b);
  endtask

  // Follows the anode rotation and checks each digit against the word
  task automatic scan_digits(input logic [31:0] word);
    int         k;
    int         dwell;
    int         changes;
    logic [7:0] exp_an;
    k       = -1;
    dwell   = 0;
    changes = 0;
    @(negedge clk);
    for (int j = 0; j < 8; j++) begin
      if (an == ~(8'b1 << j)) begin
        k = j;
      end
    end
    if (k < 0) begin
      report_error($sformatf("anode pattern %02h is not one-hot low", an));
      return;
    end
    for (int s = 0; s < SCAN_SAMPLES; s++) begin
      if (an == ~(8'b1 << ((k + 1) % 8))) begin
        if (changes > 0 && dwell != SCAN_DIV) begin
          report_error($sformatf("digit %0d held %0d clocks", k, dwell));
        end
        k = (k + 1) % 8;
        dwell = 0;
        changes++;
      end
      dwell++;
      exp_an = ~(8'b1 << k);
      check_seg("an/sev_out", an, sev_out, exp_an, mmio_pkg::seg_table[word[4*k +: 4]]);
      @(negedge clk);
    end
    if (changes < 8) begin
      report_error("anode scan did not visit all eight digits");
    end
  endtask

  task automatic display_both_words();
    logic [31:0] core_word;
    logic [31:0] debug_word;
    core_word  = next_rand();
    debug_word = next_rand();
    write_reg(1'b0, mmio_pkg::disp_core, core_word, 1'b0);
    write_reg(1'b1, mmio_pkg::disp_debug, debug_word, 1'b0);
    scan_digits(core_word);
    debug = 1'b1;
    scan_digits(debug_word);
    debug = 1'b0;
  endtask

  task automatic run_counter();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    int          polls;
    write_reg(1'b0, mmio_pkg::cnt_compare, CMP_VALUE, 1'b0);
    write_reg(1'b0, mmio_pkg::cnt_ctrl, 32'h3, 1'b0);
    read_reg(1'b0, mmio_pkg::cnt_value, 1'b0, a);
    read_reg(1'b0, mmio_pkg::cnt_value, 1'b0, b);
    if (b <= a) begin
      report_error($sformatf("counter did not increase, %0d then %0d", a, b));
    end
    polls = 0;
    do begin
      read_reg(1'b0, mmio_pkg::cnt_status, 1'b0, data);
      polls++;
    end while (!data[0] && polls < 30);
    if (!data[0]) begin
      report_error("counter match flag never set");
    end
    check_word("cnt_irq", {31'b0, cnt_irq}, 32'd1);
    write_reg(1'b1, mmio_pkg::cnt_status, 32'h1, 1'b0);
    expect_reg(1'b0, mmio_pkg::cnt_status, 32'h0);
    check_word("cnt_irq", {31'b0, cnt_irq}, 32'd0);
    write_reg(1'b0, mmio_pkg::cnt_ctrl, 32'h3, 1'b0);
    read_reg(1'b0, mmio_pkg::cnt_value, 1'b0, data);
    if (data >= CMP_VALUE) begin
      report_error($sformatf("counter read %0d after clear", data));
    end
    write_reg(1'b0, mmio_pkg::cnt_ctrl, 32'h0, 1'b0);
  endtask

  task automatic transmit_bytes();
    logic [7:0]         b;
    mmio_pkg::apb_rsp_t rsp;
    int                 rejected;
    int                 waited;
    for (int i = 0; i < 3; i++) begin
      b = 8'(next_rand());
      write_reg(1'b0, mmio_pkg::uart_data, {24'b0, b}, 1'b0);
      exp_q.push_back(b);
    end
    // Burst while the first byte is still on the line
    rejected = 0;
    for (int i = 0; i < 5; i++) begin
      b = 8'(next_rand());
      bus_xfer(1'b1, mmio_pkg::uart_data, 1'b1, {24'b0, b}, rsp);
      if (rsp.pslverr) begin
        rejected++;
      end else begin
        exp_q.push_back(b);
      end
    end
    if (rejected == 0) begin
      report_error("no write was rejected while the UART FIFO was full");
    end
    waited = 0;
    while (exp_q.size() != 0 && waited < UART_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d UART bytes never arrived", exp_q.size()));
    end
    repeat (BAUD_DIV) @(negedge clk);
    expect_reg(1'b0, mmio_pkg::uart_status, 32'h2);
  endtask

  // Finds each start bit and samples every bit in its middle
  initial begin : tx_monitor
    logic [7:0] got;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (BAUD_DIV / 2) @(negedge clk);
        if (tx !== 1'b0) begin
          report_error("tx start bit too short");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (BAUD_DIV) @(negedge clk);
          got[i] = tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        if (tx !== 1'b1) begin
          report_error("tx stop bit missing");
        end
        if (exp_q.size() == 0) begin
          report_error($sformatf("unexpected byte %02h on tx", got));
        end else begin
          check_word("tx byte", {24'b0, got}, {24'b0, exp_q.pop_front()});
        end
      end
    end
  end

  initial begin : watchdog
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Run did not finish within %0d clock cycles", RUN_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    core_req = '0;
    dbg_req  = '0;
    debug    = 1'b0;
    errors   = 0;
    rng      = 32'hcecd81ea;
    wait (rst_n === 1'b1);
    // Reset values before any traffic
    check_word("tx", {31'b0, tx}, 32'd1);
    check_word("cnt_irq", {31'b0, cnt_irq}, 32'd0);
    check_word("core_rsp.pready", {31'b0, core_rsp.pready}, 32'd0);
    check_word("dbg_rsp.pready", {31'b0, dbg_rsp.pready}, 32'd0);
    check_seg("an/sev_out", an, sev_out, 8'hFE, mmio_pkg::seg_table[0]);
    access_registers();
    contend_for_bus();
    display_both_words();
    run_counter();
    transmit_bytes();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: tb/tb_clock.sv
module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the flops
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: verilog/mmio_top.sv
module mmio_top #(
  parameter int SCAN_DIV   = 1000,
  parameter int BAUD_DIV   = 217,
  parameter int FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  mmio_pkg::apb_req_t core_req,
  output mmio_pkg::apb_rsp_t core_rsp,
  input  mmio_pkg::apb_req_t dbg_req,
  output mmio_pkg::apb_rsp_t dbg_rsp,
  input  logic               debug,
  output logic [7:0]         an,
  output logic [6:0]         sev_out,
  output logic               tx,
  output logic               cnt_irq
);

  mmio_pkg::apb_req_t bus_req;
  mmio_pkg::apb_rsp_t bus_rsp;
  logic               disp_sel;
  logic               cnt_sel;
  logic               uart_sel;
  logic               uart_full;
  logic [31:0]        disp_rdata;
  logic [31:0]        cnt_rdata;
  logic [31:0]        uart_rdata;

  apb_arbiter arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .dbg_req  (dbg_req),
    .dbg_rsp  (dbg_rsp),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp)
  );

  mmio_decoder dec (
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .disp_sel   (disp_sel),
    .cnt_sel    (cnt_sel),
    .uart_sel   (uart_sel),
    .disp_rdata (disp_rdata),
    .cnt_rdata  (cnt_rdata),
    .uart_rdata (uart_rdata),
    .uart_full  (uart_full)
  );

  seg_display #(.SCAN_DIV(SCAN_DIV)) disp (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .sel     (disp_sel),
    .rdata   (disp_rdata),
    .debug   (debug),
    .an      (an),
    .sev_out (sev_out)
  );

  event_counter cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .sel     (cnt_sel),
    .rdata   (cnt_rdata),
    .irq     (cnt_irq)
  );

  uart_tx #(
    .BAUD_DIV   (BAUD_DIV),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uart (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .sel     (uart_sel),
    .rdata   (uart_rdata),
    .full    (uart_full),
    .tx      (tx)
  );

endmodule

// File: verilog/uart_tx.sv
module uart_tx #(
  parameter int BAUD_DIV   = 217,
  parameter int FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  mmio_pkg::apb_req_t bus_req,
  input  logic               sel,
  output logic [31:0]        rdata,
  output logic               full,
  output logic               tx
);

  localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  logic [7:0]           fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     level;
  logic                 empty;
  logic                 push;
  logic                 pop;
  mmio_pkg::uart_state_e state;
  logic [BAUD_W-1:0]    baud_cnt;
  logic                 baud_end;
  logic [2:0]           bit_idx;
  logic [7:0]           shift;
  logic                 busy;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (level == CNT_W'(FIFO_DEPTH));
  assign empty = (level == '0);
  assign busy  = (state != mmio_pkg::tx_idle);
  assign push  = sel & bus_req.penable & bus_req.pwrite &
                 (bus_req.paddr == mmio_pkg::uart_data) & ~full;
  assign pop   = ~busy & ~empty;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= bus_req.pwdata[7:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      level <= level + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Baud counter restarts at every bit boundary
  assign baud_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= mmio_pkg::tx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      if (!busy || baud_end) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
      case (state)
        mmio_pkg::tx_idle: begin
          if (pop) begin
            state <= mmio_pkg::tx_start;
          end
        end
        mmio_pkg::tx_start: begin
          if (baud_end) begin
            state   <= mmio_pkg::tx_data;
            bit_idx <= '0;
          end
        end
        mmio_pkg::tx_data: begin
          if (baud_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= mmio_pkg::tx_stop;
            end
          end
        end
        default: begin
          if (baud_end) begin
            state <= mmio_pkg::tx_idle;
          end
        end
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clk) begin
    if (pop) begin
      shift <= fifo_mem[rd_ptr];
    end else if (state == mmio_pkg::tx_data && baud_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  always_comb begin
    case (state)
      mmio_pkg::tx_start: tx = 1'b0;
      mmio_pkg::tx_data:  tx = shift[0];
      default:            tx = 1'b1;
    endcase
  end

  assign rdata = (bus_req.paddr == mmio_pkg::uart_status) ?
                 {29'b0, busy, empty, full} : '0;

endmodule

// File: verilog/event_counter.sv
module event_counter (
  input  logic               clk,
  input  logic               rst_n,
  input  mmio_pkg::apb_req_t bus_req,
  input  logic               sel,
  output logic [31:0]        rdata,
  output logic               irq
);

  logic [31:0] value;
  logic [31:0] compare;
  logic        enable;
  logic        match_flag;
  logic        ovf_flag;
  logic        wr_en;
  logic        do_clear;
  logic        hit_match;
  logic        hit_wrap;

  assign wr_en     = sel & bus_req.penable & bus_req.pwrite;
  assign do_clear  = wr_en & (bus_req.paddr == mmio_pkg::cnt_ctrl) & bus_req.pwdata[1];
  assign hit_match = enable & (value == compare);
  assign hit_wrap  = enable & (value == '1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value      <= '0;
      compare    <= '0;
      enable     <= 1'b0;
      match_flag <= 1'b0;
      ovf_flag   <= 1'b0;
    end else begin
      if (do_clear) begin
        value <= '0;
      end else if (enable) begin
        value <= value + 1'b1;
      end
      if (wr_en && bus_req.paddr == mmio_pkg::cnt_compare) begin
        compare <= bus_req.pwdata;
      end
      if (wr_en && bus_req.paddr == mmio_pkg::cnt_ctrl) begin
        enable <= bus_req.pwdata[0];
      end
      // Write 1 to clear, a new event in the same cycle wins
      if (wr_en && bus_req.paddr == mmio_pkg::cnt_status) begin
        match_flag <= (match_flag & ~bus_req.pwdata[0]) | hit_match;
        ovf_flag   <= (ovf_flag & ~bus_req.pwdata[1]) | hit_wrap;
      end else begin
        match_flag <= match_flag | hit_match;
        ovf_flag   <= ovf_flag | hit_wrap;
      end
    end
  end

  always_comb begin
    case (bus_req.paddr)
      mmio_pkg::cnt_value:   rdata = value;
      mmio_pkg::cnt_compare: rdata = compare;
      mmio_pkg::cnt_ctrl:    rdata = {31'b0, enable};
      mmio_pkg::cnt_status:  rdata = {30'b0, ovf_flag, match_flag};
      default:               rdata = '0;
    endcase
  end

  assign irq = match_flag | ovf_flag;

endmodule

// File: verilog/seg_display.sv
module seg_display #(
  parameter int SCAN_DIV = 1000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  mmio_pkg::apb_req_t bus_req,
  input  logic               sel,
  output logic [31:0]        rdata,
  input  logic               debug,
  output logic [7:0]         an,
  output logic [6:0]         sev_out
);

  localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [31:0]      core_word;
  logic [31:0]      debug_word;
  logic [31:0]      shown;
  logic             wr_en;
  logic [DIV_W-1:0] div_cnt;
  logic             scan_tick;
  logic [3:0]       nibble;

  assign wr_en = sel & bus_req.penable & bus_req.pwrite;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_word  <= '0;
      debug_word <= '0;
    end else if (wr_en) begin
      if (bus_req.paddr == mmio_pkg::disp_debug) begin
        debug_word <= bus_req.pwdata;
      end else begin
        core_word <= bus_req.pwdata;
      end
    end
  end

  assign rdata = (bus_req.paddr == mmio_pkg::disp_debug) ? debug_word : core_word;

  // Scan rate from a clock enable instead of a divided clock
  assign scan_tick = (div_cnt == DIV_W'(SCAN_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (scan_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // One-hot-low anode, digit 0 first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      an <= 8'b1111_1110;
    end else if (scan_tick) begin
      an <= {an[6:0], an[7]};
    end
  end

  assign shown = debug ? debug_word : core_word;

  // Pick the nibble belonging to the active anode
  always_comb begin
    nibble = shown[3:0];
    for (int k = 0; k < 8; k++) begin
      if (!an[k]) begin
        nibble = shown[4*k +: 4];
      end
    end
  end

  assign sev_out = mmio_pkg::seg_table[nibble];

endmodule

// File: verilog/mmio_decoder.sv
module mmio_decoder (
  input  mmio_pkg::apb_req_t bus_req,
  output mmio_pkg::apb_rsp_t bus_rsp,
  output logic               disp_sel,
  output logic               cnt_sel,
  output logic               uart_sel,
  input  logic [31:0]        disp_rdata,
  input  logic [31:0]        cnt_rdata,
  input  logic [31:0]        uart_rdata,
  input  logic               uart_full
);

  mmio_pkg::mmio_reg_e reg_addr;
  logic [31:0]         rdata;
  logic                err;
  logic                hit_disp;
  logic                hit_cnt;
  logic                hit_uart;

  assign reg_addr = mmio_pkg::mmio_reg_e'(bus_req.paddr);

  always_comb begin
    hit_disp = 1'b0;
    hit_cnt  = 1'b0;
    hit_uart = 1'b0;
    rdata    = '0;
    err      = 1'b0;
    case (reg_addr)
      mmio_pkg::disp_core, mmio_pkg::disp_debug: begin
        hit_disp = 1'b1;
        rdata    = disp_rdata;
      end
      mmio_pkg::cnt_value: begin
        hit_cnt = 1'b1;
        rdata   = cnt_rdata;
        err     = bus_req.pwrite;
      end
      mmio_pkg::cnt_compare, mmio_pkg::cnt_ctrl, mmio_pkg::cnt_status: begin
        hit_cnt = 1'b1;
        rdata   = cnt_rdata;
      end
      mmio_pkg::uart_data: begin
        hit_uart = 1'b1;
        rdata    = uart_rdata;
        // Byte is dropped when the FIFO has no room
        err      = bus_req.pwrite & uart_full;
      end
      mmio_pkg::uart_status: begin
        hit_uart = 1'b1;
        rdata    = uart_rdata;
        err      = bus_req.pwrite;
      end
      default: begin
        err = 1'b1;
      end
    endcase
  end

  // A rejected access never reaches the peripheral
  assign disp_sel = bus_req.psel & hit_disp & ~err;
  assign cnt_sel  = bus_req.psel & hit_cnt & ~err;
  assign uart_sel = bus_req.psel & hit_uart & ~err;

  assign bus_rsp.prdata  = rdata;
  assign bus_rsp.pready  = bus_req.penable;
  assign bus_rsp.pslverr = bus_req.penable & err;

endmodule

// File: verilog/apb_arbiter.sv
module apb_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  mmio_pkg::apb_req_t core_req,
  output mmio_pkg::apb_rsp_t core_rsp,
  input  mmio_pkg::apb_req_t dbg_req,
  output mmio_pkg::apb_rsp_t dbg_rsp,
  output mmio_pkg::apb_req_t bus_req,
  input  mmio_pkg::apb_rsp_t bus_rsp
);

  mmio_pkg::arb_state_e state;
  mmio_pkg::apb_req_t   granted;
  logic                 owner_dbg;
  // Winner of the last contended grant
  logic                 last_dbg;
  logic                 grant_dbg;
  logic                 in_access;

  // Debug wins when alone, or on contention when core won last time
  assign grant_dbg = dbg_req.psel & (~core_req.psel | ~last_dbg);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= mmio_pkg::arb_idle;
      owner_dbg <= 1'b0;
      last_dbg  <= 1'b1;
    end else begin
      case (state)
        mmio_pkg::arb_idle: begin
          if (core_req.psel | dbg_req.psel) begin
            state     <= mmio_pkg::arb_setup;
            owner_dbg <= grant_dbg;
            if (core_req.psel & dbg_req.psel) begin
              last_dbg <= grant_dbg;
            end
          end
        end
        mmio_pkg::arb_setup: begin
          state <= mmio_pkg::arb_access;
        end
        mmio_pkg::arb_access: begin
          if (bus_rsp.pready) begin
            state <= mmio_pkg::arb_idle;
          end
        end
        default: begin
          state <= mmio_pkg::arb_idle;
        end
      endcase
    end
  end

  assign granted   = owner_dbg ? dbg_req : core_req;
  assign in_access = (state == mmio_pkg::arb_access);

  // Replay the winner's request with our own phase control
  always_comb begin
    bus_req = '0;
    if (state != mmio_pkg::arb_idle) begin
      bus_req         = granted;
      bus_req.psel    = 1'b1;
      bus_req.penable = in_access;
    end
  end

  // Only the owner sees the response, the other master waits
  assign core_rsp = (in_access && !owner_dbg) ? bus_rsp : '0;
  assign dbg_rsp  = (in_access && owner_dbg) ? bus_rsp : '0;

endmodule

// File: verilog/mmio_pkg.sv
package mmio_pkg;

  // Request from a master, held stable through setup and access
  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Register map, byte offsets on the peripheral bus
  typedef enum logic [7:0] {
    disp_core   = 8'h00,
    disp_debug  = 8'h04,
    cnt_value   = 8'h10,
    cnt_compare = 8'h14,
    cnt_ctrl    = 8'h18,
    cnt_status  = 8'h1C,
    uart_data   = 8'h20,
    uart_status = 8'h24
  } mmio_reg_e;

  typedef enum logic [1:0] {
    arb_idle,
    arb_setup,
    arb_access
  } arb_state_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } uart_state_e;

  // Active low segments, bit 6 is a and bit 0 is g
  localparam logic [6:0] seg_table [16] = '{
    7'h01, 7'h4F, 7'h12, 7'h06,
    7'h4C, 7'h24, 7'h20, 7'h0F,
    7'h00, 7'h04, 7'h08, 7'h60,
    7'h31, 7'h42, 7'h30, 7'h38
  };

endpackage
